/* priv_block.f */
design/priv_isa_pkg.sv
design/priv_internal_if.sv
design/priv_csr_decode.sv
design/priv_csr_file.sv
design/priv_trap_handler.sv
design/priv_block.sv
testbench/priv_block_tb.sv

/* Bender.yml */
package:
  name: priv_block

sources:
  - design/priv_isa_pkg.sv
  - design/priv_internal_if.sv
  - design/priv_csr_decode.sv
  - design/priv_csr_file.sv
  - design/priv_trap_handler.sv
  - design/priv_block.sv
  - target: test
    files:
      - testbench/priv_block_tb.sv

/* testbench/priv_block_tb.sv */
/* single hart, HART_ID 0; mscratch has no reset, so its first read is not checked.
   epc is held at 0x1236 for every trap, so mepc reads 0x1234 */
`timescale 1ns/10ps
`default_nettype none

module priv_block_tb;
    import priv_isa_pkg::*;

    typedef enum logic [2:0] {OP_NOP, OP_SWAP, OP_SET, OP_CLR, OP_RDO} op_e;

    typedef struct packed {
        op_e         op;
        csr_addr_t   addr;
        word_t       data;
        logic [7:0]  ctl;        // pipe_clear, no valid_write, instr, wb_enable, timer, illegal, mret, env
        logic [3:0]  exp_flags;  // check rdata, invalid_priv_isn, insert_pc, intr
        word_t       exp_rdata;
        word_t       exp_pc;
        priv_level_e exp_level;
    } step_t;

    logic        CLK, arst_n;
    csr_addr_t   csr_addr;
    logic        swap, set, clr, read_only, valid_write;
    word_t       wdata, epc, badaddr, rdata, priv_pc;
    logic        instr, wb_enable, pipe_clear, ex_mem_stall, mret, wfi, env, breakpoint;
    logic        illegal_insn, mal_insn, fault_insn, mal_l, fault_l, mal_s, fault_s;
    logic        timer_int, soft_int, ext_int;
    logic        invalid_priv_isn, insert_pc, intr;
    mstatus_t    mstatus;
    priv_level_e curr_privilege_level;

    step_t steps[$];
    word_t rng_state;
    int    step_idx;

    priv_block #(.HART_ID(0)) priv_block_i (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d %s is %h, expected %h", $time, step_idx, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d %s is %b, expected %b", $time, step_idx, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_level(input priv_level_e got, input priv_level_e exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d privilege level is %s, expected %s",
                     $time, step_idx, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_mstatus(input mstatus_t got, input mstatus_t exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d mstatus output is %h, expected %h",
                     $time, step_idx, got, exp);
            abort_run();
        end
    endtask

    task automatic add_step(input op_e op, input csr_addr_t addr, input word_t data,
                            input logic [7:0] ctl, input logic [3:0] flags, input word_t rd,
                            input word_t pc, input priv_level_e lvl);
        step_t s;
        s.op        = op;
        s.addr      = addr;
        s.data      = data;
        s.ctl       = ctl;
        s.exp_flags = flags;
        s.exp_rdata = rd;
        s.exp_pc    = pc;
        s.exp_level = lvl;
        steps.push_back(s);
    endtask

    // expected rdata is always the value before the step's clock edge
    task automatic build_table();
        word_t r;
        word_t sh;  // shadow of mscratch
        add_step(OP_SWAP, MTVEC_ADDR, 32'h103, 8'h00, 4'b1000, 32'h0, 32'h0, M_MODE);
        add_step(OP_RDO, MTVEC_ADDR, 32'h0, 8'h00, 4'b1000, 32'h100, 32'h0, M_MODE);
        r = next_rand();
        add_step(OP_SWAP, MSCRATCH_ADDR, r, 8'h00, 4'b0000, 32'h0, 32'h0, M_MODE);
        sh = r;
        add_step(OP_RDO, MSCRATCH_ADDR, 32'h0, 8'h00, 4'b1000, sh, 32'h0, M_MODE);
        r = next_rand();
        add_step(OP_SET, MSCRATCH_ADDR, r, 8'h00, 4'b1000, sh, 32'h0, M_MODE);
        sh = sh | r;
        r = next_rand();
        add_step(OP_CLR, MSCRATCH_ADDR, r, 8'h00, 4'b1000, sh, 32'h0, M_MODE);
        sh = sh & ~r;
        r = next_rand();
        add_step(OP_SWAP, MSCRATCH_ADDR, r, 8'h40, 4'b1000, sh, 32'h0, M_MODE);
        r = next_rand();
        add_step(OP_RDO, MSCRATCH_ADDR, r, 8'h00, 4'b1000, sh, 32'h0, M_MODE);
        add_step(OP_RDO, MSCRATCH_ADDR, 32'h0, 8'h00, 4'b1000, sh, 32'h0, M_MODE);
        // illegal accesses trap as illegal instructions
        add_step(OP_RDO, 12'h7C0, 32'h0, 8'h00, 4'b1110, 32'h0, 32'h100, M_MODE);
        add_step(OP_SWAP, MISA_ADDR, 32'h5, 8'h00, 4'b1110, 32'h4010_0100, 32'h100, M_MODE);
        add_step(OP_RDO, MCAUSE_ADDR, 32'h0, 8'h00, 4'b1000, CAUSE_ILLEGAL, 32'h0, M_MODE);
        add_step(OP_NOP, MSCRATCH_ADDR, 32'h0, 8'h01, 4'b0010, 32'h0, 32'h100, M_MODE);
        add_step(OP_RDO, MCAUSE_ADDR, 32'h0, 8'h00, 4'b1000, CAUSE_ECALL_M, 32'h0, M_MODE);
        add_step(OP_RDO, MEPC_ADDR, 32'h0, 8'h00, 4'b1000, 32'h1234, 32'h0, M_MODE);
        // drop MPP to U, then mret
        add_step(OP_CLR, MSTATUS_ADDR, 32'h1800, 8'h00, 4'b1000, 32'h1800, 32'h0, M_MODE);
        add_step(OP_RDO, MSTATUS_ADDR, 32'h0, 8'h00, 4'b1000, 32'h0, 32'h0, M_MODE);
        add_step(OP_NOP, MEPC_ADDR, 32'h0, 8'h02, 4'b1010, 32'h1234, 32'h1234, M_MODE);
        add_step(OP_RDO, MSTATUS_ADDR, 32'h0, 8'h00, 4'b1110, 32'h80, 32'h100, U_MODE);
        add_step(OP_NOP, MSTATUS_ADDR, 32'h0, 8'h02, 4'b1010, 32'h0, 32'h1234, M_MODE);
        add_step(OP_NOP, MSTATUS_ADDR, 32'h0, 8'h01, 4'b1010, 32'h80, 32'h100, U_MODE);
        add_step(OP_RDO, MCAUSE_ADDR, 32'h0, 8'h00, 4'b1000, CAUSE_ECALL_U, 32'h0, M_MODE);
        // timer enabled in mie but held off by mstatus.MIE
        add_step(OP_SWAP, MIE_ADDR, 32'h80, 8'h00, 4'b1000, 32'h0, 32'h0, M_MODE);
        add_step(OP_RDO, MIP_ADDR, 32'h0, 8'h08, 4'b1000, 32'h80, 32'h0, M_MODE);
        add_step(OP_SET, MSTATUS_ADDR, 32'h8, 8'h08, 4'b1000, 32'h0, 32'h0, M_MODE);
        add_step(OP_NOP, MIP_ADDR, 32'h0, 8'h08, 4'b1011, 32'h80, 32'h100, M_MODE);
        add_step(OP_RDO, MCAUSE_ADDR, 32'h0, 8'h00, 4'b1000, INT_TIMER_M, 32'h0, M_MODE);
        add_step(OP_SET, MSTATUS_ADDR, 32'h8, 8'h00, 4'b1000, 32'h1880, 32'h0, M_MODE);
        add_step(OP_NOP, MIP_ADDR, 32'h0, 8'h0C, 4'b1010, 32'h80, 32'h100, M_MODE);
        add_step(OP_RDO, MCAUSE_ADDR, 32'h0, 8'h00, 4'b1000, CAUSE_ILLEGAL, 32'h0, M_MODE);
        // minstret moves only when instr and wb_enable are both high
        add_step(OP_RDO, MINSTRET_ADDR, 32'h0, 8'h30, 4'b1000, 32'd0, 32'h0, M_MODE);
        add_step(OP_RDO, MINSTRET_ADDR, 32'h0, 8'h30, 4'b1000, 32'd1, 32'h0, M_MODE);
        add_step(OP_RDO, MINSTRET_ADDR, 32'h0, 8'h20, 4'b1000, 32'd2, 32'h0, M_MODE);
        add_step(OP_RDO, MINSTRET_ADDR, 32'h0, 8'h10, 4'b1000, 32'd2, 32'h0, M_MODE);
        add_step(OP_RDO, MINSTRET_ADDR, 32'h0, 8'h30, 4'b1000, 32'd2, 32'h0, M_MODE);
        add_step(OP_RDO, MINSTRET_ADDR, 32'h0, 8'h00, 4'b1000, 32'd3, 32'h0, M_MODE);
        r = next_rand();
        add_step(OP_SWAP, MSCRATCH_ADDR, r, 8'h81, 4'b1000, sh, 32'h0, M_MODE);  // flushed
        add_step(OP_RDO, MSCRATCH_ADDR, 32'h0, 8'h00, 4'b1000, sh, 32'h0, M_MODE);
    endtask

    task automatic drive(input step_t s);
        swap         = (s.op == OP_SWAP);
        set          = (s.op == OP_SET);
        clr          = (s.op == OP_CLR);
        read_only    = (s.op == OP_RDO);
        csr_addr     = s.addr;
        wdata        = s.data;
        pipe_clear   = s.ctl[7];
        valid_write  = ~s.ctl[6];
        instr        = s.ctl[5];
        wb_enable    = s.ctl[4];
        timer_int    = s.ctl[3];
        illegal_insn = s.ctl[2];
        mret         = s.ctl[1];
        env          = s.ctl[0];
    endtask

    // poll for the redirect inside the cycle, then land 1 ns before the rising edge
    task automatic settle(input logic want_redirect);
        int n;
        n = 0;
        do begin
            #1;
            n++;
        end while (want_redirect && !insert_pc && n < 4);
        if (want_redirect && !insert_pc) begin
            $display("no pipeline redirect seen in step %0d at %0t", step_idx, $time);
            abort_run();
        end
        #(4 - n);
    endtask

    initial begin
        arst_n       = 1'b0;
        epc          = 32'h0000_1236;
        badaddr      = '0;
        ex_mem_stall = 1'b0;
        wfi          = 1'b0;
        breakpoint   = 1'b0;
        mal_insn     = 1'b0;
        fault_insn   = 1'b0;
        mal_l        = 1'b0;
        fault_l      = 1'b0;
        mal_s        = 1'b0;
        fault_s      = 1'b0;
        soft_int     = 1'b0;
        ext_int      = 1'b0;
        step_idx     = 0;
        rng_state    = 32'hb121_141b;
        build_table();
        drive('0);
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        for (step_idx = 0; step_idx < steps.size(); step_idx++) begin
            @(negedge CLK);
            drive(steps[step_idx]);
            settle(steps[step_idx].exp_flags[1]);
            if (steps[step_idx].exp_flags[3]) begin
                check_word("rdata", rdata, steps[step_idx].exp_rdata);
            end
            // the mstatus port shows the same register as an mstatus read
            if (steps[step_idx].exp_flags[3] && steps[step_idx].addr == MSTATUS_ADDR) begin
                check_mstatus(mstatus, mstatus_t'(steps[step_idx].exp_rdata));
            end
            check_bit("invalid_priv_isn", invalid_priv_isn, steps[step_idx].exp_flags[2]);
            check_bit("insert_pc", insert_pc, steps[step_idx].exp_flags[1]);
            check_bit("intr", intr, steps[step_idx].exp_flags[0]);
            if (steps[step_idx].exp_flags[1]) begin
                check_word("priv_pc", priv_pc, steps[step_idx].exp_pc);  // only valid on redirect
            end
            check_level(curr_privilege_level, steps[step_idx].exp_level);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/priv_block.sv */
/* one hart, M and U modes; no PMP/PMA so no protection faults come out.
   CSR strobes are one-hot and ignored while ex_mem_stall or pipe_clear is high */
`timescale 1ns/10ps
`default_nettype none

module priv_block #(
    parameter int unsigned HART_ID = 0
) (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  priv_isa_pkg::csr_addr_t     csr_addr,
    input  logic                        swap,
    input  logic                        set,
    input  logic                        clr,
    input  logic                        read_only,
    input  logic                        valid_write,
    input  priv_isa_pkg::word_t         wdata,
    input  logic                        instr,
    input  logic                        wb_enable,
    input  logic                        pipe_clear,
    input  logic                        ex_mem_stall,
    input  logic                        mret,
    input  logic                        wfi,
    input  logic                        env,
    input  logic                        breakpoint,
    input  logic                        illegal_insn,
    input  logic                        mal_insn,
    input  logic                        fault_insn,
    input  logic                        mal_l,
    input  logic                        fault_l,
    input  logic                        mal_s,
    input  logic                        fault_s,
    input  priv_isa_pkg::word_t         epc,
    input  priv_isa_pkg::word_t         badaddr,
    input  logic                        timer_int,
    input  logic                        soft_int,
    input  logic                        ext_int,
    output priv_isa_pkg::word_t         rdata,
    output logic                        invalid_priv_isn,
    output logic                        insert_pc,
    output logic                        intr,
    output priv_isa_pkg::word_t         priv_pc,
    output priv_isa_pkg::mstatus_t      mstatus,
    output priv_isa_pkg::priv_level_e   curr_privilege_level
);
    import priv_isa_pkg::*;

    priv_internal_if prv_intern_if ();

    logic csr_valid_write;

    assign csr_valid_write = valid_write & ~pipe_clear & ~ex_mem_stall;

    priv_csr_decode csr_decode (.swap(swap), .set(set), .clr(clr), .read_only(read_only),
        .valid_write(csr_valid_write), .wdata(wdata), .intf(prv_intern_if));

    priv_csr_file #(.HART_ID(HART_ID)) csr_file (.CLK(CLK), .arst_n(arst_n),
        .csr_addr(csr_addr), .intf(prv_intern_if));

    priv_trap_handler trap_handler (.mal_insn(mal_insn), .fault_insn(fault_insn),
        .illegal_insn(illegal_insn | invalid_priv_isn), .breakpoint(breakpoint), .env(env),
        .mal_l(mal_l), .fault_l(fault_l), .mal_s(mal_s), .fault_s(fault_s), .mret(mret),
        .pipe_clear(pipe_clear), .ex_mem_stall(ex_mem_stall), .epc(epc), .badaddr(badaddr),
        .insert_pc(insert_pc), .intr(intr), .priv_pc(priv_pc), .intf(prv_intern_if));

    assign prv_intern_if.csr_addr = csr_addr;
    assign prv_intern_if.inst_ret = wb_enable & instr;

    // only machine interrupts exist and they pend in either mode
    assign prv_intern_if.timer_int = timer_int;
    assign prv_intern_if.soft_int  = soft_int;
    assign prv_intern_if.ext_int   = ext_int;

    // wfi traps from U mode only when TW is set
    assign invalid_priv_isn = prv_intern_if.invalid_csr
                            | (mret & (prv_intern_if.curr_level != M_MODE))
                            | (wfi & (prv_intern_if.curr_level == U_MODE)
                                   & prv_intern_if.curr_mstatus.tw);

    assign rdata                = prv_intern_if.old_csr_val;
    assign mstatus              = prv_intern_if.curr_mstatus;
    assign curr_privilege_level = prv_intern_if.curr_level;

endmodule

`default_nettype wire

/* design/priv_trap_handler.sv */
/* exceptions beat interrupts; nothing is accepted in a stalled or flushed
   cycle, and redirect outputs are combinational in the trap cycle */
`timescale 1ns/10ps
`default_nettype none

module priv_trap_handler (
    input  logic                mal_insn,
    input  logic                fault_insn,
    input  logic                illegal_insn,  // includes illegal privileged access
    input  logic                breakpoint,
    input  logic                env,
    input  logic                mal_l,
    input  logic                fault_l,
    input  logic                mal_s,
    input  logic                fault_s,
    input  logic                mret,
    input  logic                pipe_clear,
    input  logic                ex_mem_stall,
    input  priv_isa_pkg::word_t epc,
    input  priv_isa_pkg::word_t badaddr,
    output logic                insert_pc,
    output logic                intr,
    output priv_isa_pkg::word_t priv_pc,
    priv_internal_if.trap       intf
);
    import priv_isa_pkg::*;

    logic   accept;
    logic   exc;
    cause_t exc_cause;
    word_t  exc_tval;
    logic   glob_en;
    logic   ext_pend, soft_pend, timer_pend;
    logic   irq;
    cause_t irq_cause;

    assign accept = ~pipe_clear & ~ex_mem_stall;

    assign exc = mal_insn | fault_insn | illegal_insn | breakpoint | env
               | mal_l | fault_l | mal_s | fault_s;

    // fixed priority, first match wins
    always_comb begin
        if (mal_insn)          exc_cause = CAUSE_INSN_MAL;
        else if (fault_insn)   exc_cause = CAUSE_INSN_FAULT;
        else if (illegal_insn) exc_cause = CAUSE_ILLEGAL;
        else if (breakpoint)   exc_cause = CAUSE_BREAK;
        else if (env)          exc_cause = (intf.curr_level == M_MODE) ? CAUSE_ECALL_M
                                                                       : CAUSE_ECALL_U;
        else if (mal_l)        exc_cause = CAUSE_LOAD_MAL;
        else if (fault_l)      exc_cause = CAUSE_LOAD_FAULT;
        else if (mal_s)        exc_cause = CAUSE_STORE_MAL;
        else                   exc_cause = CAUSE_STORE_FAULT;
    end

    // only address faults report an address
    assign exc_tval = (exc_cause inside {CAUSE_ILLEGAL, CAUSE_BREAK, CAUSE_ECALL_U,
                                         CAUSE_ECALL_M}) ? '0 : badaddr;

    // M-level interrupts are always enabled while in U mode
    assign glob_en    = intf.curr_mstatus.mie | (intf.curr_level == U_MODE);
    assign ext_pend   = intf.mip[MEIP_BIT] & intf.mie[MEIP_BIT];
    assign soft_pend  = intf.mip[MSIP_BIT] & intf.mie[MSIP_BIT];
    assign timer_pend = intf.mip[MTIP_BIT] & intf.mie[MTIP_BIT];
    assign irq        = glob_en & (ext_pend | soft_pend | timer_pend);

    always_comb begin
        if (ext_pend)       irq_cause = INT_EXT_M;
        else if (soft_pend) irq_cause = INT_SOFT_M;
        else                irq_cause = INT_TIMER_M;
    end

    assign intf.trap_take  = accept & (exc | irq);
    assign intf.trap_cause = exc ? exc_cause : irq_cause;
    assign intf.trap_tval  = exc ? exc_tval : '0;
    assign intf.trap_epc   = epc;
    assign intf.mret_take  = accept & mret & (intf.curr_level == M_MODE) & ~exc & ~irq;

    assign intr      = intf.trap_take & ~exc;
    assign insert_pc = intf.trap_take | intf.mret_take;
    assign priv_pc   = intf.trap_take ? intf.mtvec : intf.mepc;  // direct mode base

endmodule

`default_nettype wire

/* design/priv_csr_file.sv */
/* mtvec is direct mode only and mip follows the interrupt lines; a trap
   in the same cycle as a CSR write cancels that write */
`timescale 1ns/10ps
`default_nettype none

module priv_csr_file #(
    parameter int unsigned HART_ID = 0
) (
    input logic                     CLK,
    input logic                     arst_n,
    input priv_isa_pkg::csr_addr_t  csr_addr,
    priv_internal_if.csr_file       intf
);
    import priv_isa_pkg::*;

    mstatus_t    mstatus_q;
    mstatus_t    mstatus_wr;
    priv_level_e level_q;
    word_t       mie_q, mtvec_q, mepc_q;
    word_t       mcause_q, mtval_q, mscratch_q;
    word_t       mcycle_q, minstret_q;
    word_t       mip_w;
    logic        wr_en;

    assign wr_en = intf.csr_write_en & ~intf.trap_take;

    always_comb begin
        mip_w           = '0;
        mip_w[MSIP_BIT] = intf.soft_int;
        mip_w[MTIP_BIT] = intf.timer_int;
        mip_w[MEIP_BIT] = intf.ext_int;
    end

    // keep only the implemented fields, MPP is WARL between U and M
    always_comb begin
        mstatus_wr      = '0;
        mstatus_wr.mie  = intf.new_csr_val[MIE_BIT];
        mstatus_wr.mpie = intf.new_csr_val[MPIE_BIT];
        mstatus_wr.mpp  = (intf.new_csr_val[12:11] == 2'b11) ? M_MODE : U_MODE;
        mstatus_wr.tw   = intf.new_csr_val[21];
    end

    // privilege level and mstatus stack
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_q <= '0;
            level_q   <= M_MODE;
        end else if (intf.trap_take) begin
            mstatus_q.mpie <= mstatus_q.mie;
            mstatus_q.mie  <= 1'b0;
            mstatus_q.mpp  <= level_q;
            level_q        <= M_MODE;
        end else if (intf.mret_take) begin
            mstatus_q.mie  <= mstatus_q.mpie;
            mstatus_q.mpie <= 1'b1;
            mstatus_q.mpp  <= U_MODE;
            level_q        <= mstatus_q.mpp;
        end else if (wr_en && csr_addr == MSTATUS_ADDR) begin
            mstatus_q <= mstatus_wr;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            mie_q      <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            if (intf.trap_take) begin
                mepc_q <= {intf.trap_epc[31:2], 2'b00};
            end else if (wr_en && csr_addr == MEPC_ADDR) begin
                mepc_q <= {intf.new_csr_val[31:2], 2'b00};
            end
            if (wr_en && csr_addr == MTVEC_ADDR) begin
                mtvec_q <= {intf.new_csr_val[31:2], 2'b00};  // mode bits stay 0
            end
            if (wr_en && csr_addr == MIE_ADDR) begin
                mie_q[MSIP_BIT] <= intf.new_csr_val[MSIP_BIT];
                mie_q[MTIP_BIT] <= intf.new_csr_val[MTIP_BIT];
                mie_q[MEIP_BIT] <= intf.new_csr_val[MEIP_BIT];
            end
            // a software write replaces the increment for that cycle
            mcycle_q   <= (wr_en && csr_addr == MCYCLE_ADDR) ? intf.new_csr_val
                                                             : mcycle_q + 32'd1;
            minstret_q <= (wr_en && csr_addr == MINSTRET_ADDR) ? intf.new_csr_val
                                                               : minstret_q + 32'(intf.inst_ret);
        end
    end

    always_ff @(posedge CLK) begin
        if (intf.trap_take) begin
            mcause_q <= intf.trap_cause;
            mtval_q  <= intf.trap_tval;
        end else if (wr_en && csr_addr == MCAUSE_ADDR) begin
            mcause_q <= intf.new_csr_val;
        end else if (wr_en && csr_addr == MTVAL_ADDR) begin
            mtval_q <= intf.new_csr_val;
        end
        if (wr_en && csr_addr == MSCRATCH_ADDR) begin
            mscratch_q <= intf.new_csr_val;
        end
    end

    always_comb begin
        case (csr_addr)
            MSTATUS_ADDR:  intf.old_csr_val = mstatus_q;
            MISA_ADDR:     intf.old_csr_val = MISA_VALUE;
            MIE_ADDR:      intf.old_csr_val = mie_q;
            MTVEC_ADDR:    intf.old_csr_val = mtvec_q;
            MSCRATCH_ADDR: intf.old_csr_val = mscratch_q;
            MEPC_ADDR:     intf.old_csr_val = mepc_q;
            MCAUSE_ADDR:   intf.old_csr_val = mcause_q;
            MTVAL_ADDR:    intf.old_csr_val = mtval_q;
            MIP_ADDR:      intf.old_csr_val = mip_w;
            MCYCLE_ADDR:   intf.old_csr_val = mcycle_q;
            MINSTRET_ADDR: intf.old_csr_val = minstret_q;
            MHARTID_ADDR:  intf.old_csr_val = word_t'(HART_ID);
            default:       intf.old_csr_val = '0;
        endcase
    end

    assign intf.curr_level   = level_q;
    assign intf.curr_mstatus = mstatus_q;
    assign intf.mie          = mie_q;
    assign intf.mip          = mip_w;
    assign intf.mtvec        = mtvec_q;
    assign intf.mepc         = mepc_q;

endmodule

`default_nettype wire

/* design/priv_csr_decode.sv */
/* one strobe is expected per cycle; set/clear with a zero mask counts as a
   read, so misa and mhartid may be read that way */
`timescale 1ns/10ps
`default_nettype none

module priv_csr_decode (
    input logic                swap,
    input logic                set,
    input logic                clr,
    input logic                read_only,
    input logic                valid_write,  // low in stalled or flushed cycles
    input priv_isa_pkg::word_t wdata,
    priv_internal_if.decode    intf
);
    import priv_isa_pkg::*;

    logic implemented;
    logic ro_csr;
    logic access;
    logic wants_write;
    logic illegal;

    always_comb begin
        case (intf.csr_addr)
            MSTATUS_ADDR, MISA_ADDR, MIE_ADDR, MTVEC_ADDR,
            MSCRATCH_ADDR, MEPC_ADDR, MCAUSE_ADDR, MTVAL_ADDR,
            MIP_ADDR, MCYCLE_ADDR, MINSTRET_ADDR, MHARTID_ADDR: implemented = 1'b1;
            default:                                            implemented = 1'b0;
        endcase
    end

    assign ro_csr = (intf.csr_addr == MISA_ADDR) || (intf.csr_addr == MHARTID_ADDR);
    assign access = swap | set | clr | read_only;

    // a zero mask on set/clear leaves the register alone
    assign wants_write = ~read_only & (swap | ((set | clr) & (|wdata)));

    // every implemented CSR is machine level, so U mode may touch none
    assign illegal = access & (~implemented
                               | (wants_write & ro_csr)
                               | (intf.curr_level != M_MODE));

    assign intf.invalid_csr  = illegal;
    assign intf.csr_write_en = valid_write & wants_write & ~illegal;

    always_comb begin
        if (swap) begin
            intf.new_csr_val = wdata;
        end else if (set) begin
            intf.new_csr_val = intf.old_csr_val | wdata;
        end else if (clr) begin
            intf.new_csr_val = intf.old_csr_val & ~wdata;
        end else begin
            intf.new_csr_val = intf.old_csr_val;  // read only, never written
        end
    end

endmodule

`default_nettype wire

/* design/priv_internal_if.sv */
/* joins CSR decode, CSR file and trap handler inside priv_block;
   all signals are same-cycle levels with no handshake */
`timescale 1ns/10ps
`default_nettype none

interface priv_internal_if;
    import priv_isa_pkg::*;

    csr_addr_t   csr_addr;
    logic        csr_write_en;
    word_t       new_csr_val;
    word_t       old_csr_val;
    logic        invalid_csr;

    priv_level_e curr_level;
    mstatus_t    curr_mstatus;
    word_t       mie, mip, mtvec, mepc;

    logic        trap_take;
    cause_t      trap_cause;
    word_t       trap_tval;
    word_t       trap_epc;
    logic        mret_take;

    logic        inst_ret;
    logic        timer_int, soft_int, ext_int;  // machine lines after gating

    modport decode (
        input  csr_addr, old_csr_val, curr_level,
        output csr_write_en, new_csr_val, invalid_csr
    );

    modport csr_file (
        input  csr_write_en, new_csr_val, trap_take, trap_cause, trap_tval, trap_epc,
        input  mret_take, inst_ret, timer_int, soft_int, ext_int,
        output old_csr_val, curr_level, curr_mstatus, mie, mip, mtvec, mepc
    );

    modport trap (
        input  curr_level, curr_mstatus, mie, mip, mtvec, mepc,
        output trap_take, trap_cause, trap_tval, trap_epc, mret_take
    );

endinterface

`default_nettype wire

/* design/priv_isa_pkg.sv */
/* machine and user privilege only; supervisor state, PMP/PMA and vectored
   mtvec are absent, so those encodings are not defined here */
`default_nettype none

package priv_isa_pkg;

    typedef logic [31:0] word_t;      // CSR values, PCs and addresses
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] cause_t;     // bit 31 marks an interrupt

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        M_MODE = 2'b11
    } priv_level_e;

    // only MIE, MPIE, MPP and TW are backed by flops
    typedef struct packed {
        logic [9:0]  reserved_31_22;
        logic        tw;
        logic [7:0]  reserved_20_13;
        priv_level_e mpp;
        logic [2:0]  reserved_10_8;
        logic        mpie;
        logic [2:0]  reserved_6_4;
        logic        mie;
        logic [2:0]  reserved_2_0;
    } mstatus_t;

    // CSR addresses
    localparam csr_addr_t MSTATUS_ADDR  = 12'h300;
    localparam csr_addr_t MISA_ADDR     = 12'h301;
    localparam csr_addr_t MIE_ADDR      = 12'h304;
    localparam csr_addr_t MTVEC_ADDR    = 12'h305;
    localparam csr_addr_t MSCRATCH_ADDR = 12'h340;
    localparam csr_addr_t MEPC_ADDR     = 12'h341;
    localparam csr_addr_t MCAUSE_ADDR   = 12'h342;
    localparam csr_addr_t MTVAL_ADDR    = 12'h343;
    localparam csr_addr_t MIP_ADDR      = 12'h344;
    localparam csr_addr_t MCYCLE_ADDR   = 12'hB00;
    localparam csr_addr_t MINSTRET_ADDR = 12'hB02;
    localparam csr_addr_t MHARTID_ADDR  = 12'hF14;

    // synchronous exception codes
    localparam cause_t CAUSE_INSN_MAL    = 32'd0;
    localparam cause_t CAUSE_INSN_FAULT  = 32'd1;
    localparam cause_t CAUSE_ILLEGAL     = 32'd2;
    localparam cause_t CAUSE_BREAK       = 32'd3;
    localparam cause_t CAUSE_LOAD_MAL    = 32'd4;
    localparam cause_t CAUSE_LOAD_FAULT  = 32'd5;
    localparam cause_t CAUSE_STORE_MAL   = 32'd6;
    localparam cause_t CAUSE_STORE_FAULT = 32'd7;
    localparam cause_t CAUSE_ECALL_U     = 32'd8;
    localparam cause_t CAUSE_ECALL_M     = 32'd11;

    // machine interrupt codes
    localparam cause_t INT_SOFT_M  = 32'h8000_0003;
    localparam cause_t INT_TIMER_M = 32'h8000_0007;
    localparam cause_t INT_EXT_M   = 32'h8000_000B;

    // MXL = 32 bit, I and U extensions
    localparam word_t MISA_VALUE = 32'h4010_0100;

    // bit positions in mstatus and in mip/mie
    localparam int unsigned MIE_BIT  = 3;
    localparam int unsigned MPIE_BIT = 7;
    localparam int unsigned MSIP_BIT = 3;
    localparam int unsigned MTIP_BIT = 7;
    localparam int unsigned MEIP_BIT = 11;

endpackage

`default_nettype wire
